// File: src/lsu_pkg.sv
// load store unit shared definitions
package lsu_pkg;

  // widths and sizes
  localparam int DATA_W              = 32;
  localparam int MASK_W              = DATA_W / 8;
  localparam int REG_ADDR_W          = 5;
  localparam int TG_TAG_W            = 3;
  localparam int TG_X_W              = 6;
  localparam int TG_Y_W              = 5;
  localparam int TG_EPA_W            = DATA_W - TG_TAG_W - TG_Y_W - TG_X_W;
  localparam int DMEM_WORDS          = 1024;
  localparam int DMEM_ADDR_W         = $clog2(DMEM_WORDS);
  localparam int FIFO_DEPTH          = 4;
  localparam int FIFO_PTR_W          = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W          = $clog2(FIFO_DEPTH + 1);
  localparam int NET_CREDITS         = 2;
  localparam int NET_CNT_W           = $clog2(NET_CREDITS + 1);
  localparam int PLAIN_LOCAL_LIMIT_W = 12;

  localparam logic [DATA_W-1:0]   DRAM_PREFIX   = 32'h8000_0000;
  localparam logic [TG_TAG_W-1:0] TG_REMOTE_TAG = 3'b001;

  // operation codes
  localparam int OP_W = 3;
  localparam logic [OP_W-1:0] OP_NONE   = 3'd0;
  localparam logic [OP_W-1:0] OP_LOAD   = 3'd1;
  localparam logic [OP_W-1:0] OP_LOAD_U = 3'd2;
  localparam logic [OP_W-1:0] OP_STORE  = 3'd3;
  localparam logic [OP_W-1:0] OP_AMO    = 3'd4;
  localparam logic [OP_W-1:0] OP_LR     = 3'd5;
  localparam logic [OP_W-1:0] OP_LR_AQ  = 3'd6;

  // access sizes
  localparam int SIZE_W = 2;
  localparam logic [SIZE_W-1:0] SIZE_BYTE = 2'd0;
  localparam logic [SIZE_W-1:0] SIZE_HALF = 2'd1;
  localparam logic [SIZE_W-1:0] SIZE_WORD = 2'd2;

  // one address word, read as plain local or as tile-group
  typedef union packed {
    struct packed {
      logic [DATA_W-PLAIN_LOCAL_LIMIT_W-1:0] upper;
      logic [PLAIN_LOCAL_LIMIT_W-1:0]        offset;
    } plain;
    struct packed {
      logic [TG_TAG_W-1:0] remote;
      logic [TG_Y_W-1:0]   y_cord;
      logic [TG_X_W-1:0]   x_cord;
      logic [TG_EPA_W-1:0] epa;
    } tg;
  } lsu_addr_u;

  // remote request word, msb first: op size unsigned icache psel mask reg data addr
  localparam int REQ_ADDR_LSB     = 0;
  localparam int REQ_DATA_LSB     = REQ_ADDR_LSB + DATA_W;
  localparam int REQ_REG_LSB      = REQ_DATA_LSB + DATA_W;
  localparam int REQ_MASK_LSB     = REQ_REG_LSB + REG_ADDR_W;
  localparam int REQ_PSEL_LSB     = REQ_MASK_LSB + MASK_W;
  localparam int REQ_ICACHE_BIT   = REQ_PSEL_LSB + 2;
  localparam int REQ_UNSIGNED_BIT = REQ_ICACHE_BIT + 1;
  localparam int REQ_SIZE_LSB     = REQ_UNSIGNED_BIT + 1;
  localparam int REQ_OP_LSB       = REQ_SIZE_LSB + SIZE_W;
  localparam int REQ_W            = REQ_OP_LSB + OP_W;

  // flit layout, header carries the word address, psel gives the low bits
  localparam int FLIT_W            = 48;
  localparam logic FLIT_HDR        = 1'b0;
  localparam logic FLIT_DATA       = 1'b1;
  localparam int FLIT_KIND_BIT     = 47;
  localparam int FLIT_WRITE_BIT    = 46;
  localparam int FLIT_AMO_BIT      = 45;
  localparam int FLIT_ICACHE_BIT   = 44;
  localparam int FLIT_UNSIGNED_BIT = 43;
  localparam int FLIT_SIZE_LSB     = 41;
  localparam int FLIT_PSEL_LSB     = 39;
  localparam int FLIT_MASK_LSB     = 35;
  localparam int FLIT_REG_LSB      = 30;
  localparam int FLIT_ADDR_LSB     = 0;
  localparam int FLIT_ADDR_W       = DATA_W - 2;
  localparam int FLIT_DATA_LSB     = 0;

  // sender states
  localparam logic TX_HDR  = 1'b0;
  localparam logic TX_DATA = 1'b1;

endpackage

// File: src/lsu.sv
// load store unit
`timescale 1ns/1ps

module lsu
  import lsu_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   exe_v_i,
  input  logic [OP_W-1:0]        exe_op_i,
  input  logic [SIZE_W-1:0]      exe_size_i,
  input  logic [DATA_W-1:0]      exe_rs1_i,
  input  logic [DATA_W-1:0]      exe_rs2_i,
  input  logic [REG_ADDR_W-1:0]  exe_rd_i,
  input  logic [DATA_W-1:0]      mem_offset_i,
  input  logic [DATA_W-1:0]      pc_plus4_i,
  input  logic                   icache_miss_i,
  input  logic [TG_X_W-1:0]      tg_x_cord_i,
  input  logic [TG_Y_W-1:0]      tg_y_cord_i,
  input  logic                   fifo_credit_i,
  output logic                   stall_o,
  output logic                   dmem_v_o,
  output logic                   dmem_w_o,
  output logic [DMEM_ADDR_W-1:0] dmem_addr_o,
  output logic [DATA_W-1:0]      dmem_data_o,
  output logic [MASK_W-1:0]      dmem_mask_o,
  output logic                   reserve_o,
  output logic                   fifo_push_o,
  output logic [REQ_W-1:0]       fifo_req_o
);

  logic [DATA_W-1:0]     mem_addr;
  logic [DATA_W-1:0]     miss_addr;
  lsu_addr_u             addr_dec;
  logic                  is_plain_local;
  logic                  is_tg_local;
  logic                  is_local;
  logic                  is_load;
  logic                  is_store;
  logic                  is_amo;
  logic                  is_lr;
  logic                  want_local;
  logic                  want_remote;
  logic                  accept;
  logic [DATA_W-1:0]     store_data;
  logic [MASK_W-1:0]     store_mask;
  logic [REQ_W-1:0]      req_word;
  logic [FIFO_CNT_W-1:0] credits_q;

  assign mem_addr  = exe_rs1_i + mem_offset_i;
  assign miss_addr = (pc_plus4_i - 32'd4) | DRAM_PREFIX;

  // address decode, both views of the same word
  assign addr_dec       = mem_addr;
  assign is_plain_local = (addr_dec.plain.upper == '0);
  assign is_tg_local    = (addr_dec.tg.remote == TG_REMOTE_TAG) &&
                          (addr_dec.tg.x_cord == tg_x_cord_i) &&
                          (addr_dec.tg.y_cord == tg_y_cord_i);
  assign is_local       = is_plain_local | is_tg_local;

  assign is_load  = (exe_op_i == OP_LOAD) || (exe_op_i == OP_LOAD_U);
  assign is_store = (exe_op_i == OP_STORE);
  assign is_amo   = (exe_op_i == OP_AMO);
  assign is_lr    = (exe_op_i == OP_LR) || (exe_op_i == OP_LR_AQ);

  // replicate store data across the word, mask by size and low bits
  always_comb begin
    case (exe_size_i)
      SIZE_BYTE: begin
        store_data = {4{exe_rs2_i[7:0]}};
        store_mask = 4'b0001 << mem_addr[1:0];
      end
      SIZE_HALF: begin
        store_data = {2{exe_rs2_i[15:0]}};
        store_mask = mem_addr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        store_data = exe_rs2_i;
        store_mask = 4'b1111;
      end
    endcase
  end

  // atomics and miss fetches never touch local memory
  assign want_local  = ~icache_miss_i & is_local & (is_load | is_store | is_lr);
  assign want_remote = icache_miss_i | is_amo | ((is_load | is_store) & ~is_local);

  assign stall_o = exe_v_i & want_remote & (credits_q == '0);
  assign accept  = exe_v_i & ~stall_o;

  always_comb begin
    if (icache_miss_i) begin
      // fetch is a plain word read, only the icache flag set
      req_word = {OP_LOAD, SIZE_WORD, 1'b0, 1'b1, 2'b00, {MASK_W{1'b1}},
                  {REG_ADDR_W{1'b0}}, {DATA_W{1'b0}}, miss_addr};
    end else begin
      req_word = {exe_op_i, exe_size_i, (exe_op_i == OP_LOAD_U), 1'b0, mem_addr[1:0],
                  store_mask, exe_rd_i, store_data, mem_addr};
    end
  end

  // one credit per free buffer slot, taken at acceptance
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      credits_q <= FIFO_CNT_W'(FIFO_DEPTH);
    end else begin
      case ({accept & want_remote, fifo_credit_i})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: credits_q <= credits_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      dmem_v_o    <= 1'b0;
      reserve_o   <= 1'b0;
      fifo_push_o <= 1'b0;
    end else begin
      dmem_v_o    <= accept & want_local;
      // either lr flavor reserves
      reserve_o   <= accept & want_local & is_lr;
      fifo_push_o <= accept & want_remote;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept & want_local) begin
      dmem_w_o    <= is_store;
      dmem_addr_o <= mem_addr[2 +: DMEM_ADDR_W];
      dmem_data_o <= store_data;
      dmem_mask_o <= store_mask;
    end
    if (accept & want_remote) begin
      fifo_req_o <= req_word;
    end
  end

  // an accepted atomic shows up at the buffer, never at dmem
  a_amo_remote: assert property (@(posedge clk_i) disable iff (!reset_i)
    accept && is_amo && !icache_miss_i |=> fifo_push_o && !dmem_v_o)
    else $error("atomic routed to local memory");

  a_lr_local: assert property (@(posedge clk_i) disable iff (!reset_i)
    exe_v_i && is_lr && !icache_miss_i |-> is_local)
    else $error("load-reserved on a non-local address");

  // buffer never returns more credits than it was given
  a_credit_max: assert property (@(posedge clk_i) disable iff (!reset_i)
    credits_q <= FIFO_CNT_W'(FIFO_DEPTH))
    else $error("credit count above buffer depth");

endmodule

// File: src/dmem.sv
// tile data memory
`timescale 1ns/1ps

module dmem
  import lsu_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   v_i,
  input  logic                   w_i,
  input  logic [DMEM_ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0]      data_i,
  input  logic [MASK_W-1:0]      mask_i,
  output logic                   load_v_o,
  output logic [DATA_W-1:0]      load_data_o
);

  logic [DATA_W-1:0] mem_q [DMEM_WORDS];

  // byte lanes written only where the mask is set
  always_ff @(posedge clk_i) begin
    if (v_i && w_i) begin
      for (int i = 0; i < MASK_W; i++) begin
        if (mask_i[i]) begin
          mem_q[addr_i][i*8 +: 8] <= data_i[i*8 +: 8];
        end
      end
    end
  end

  // full word back, extraction happens at writeback
  always_ff @(posedge clk_i) begin
    if (v_i && !w_i) begin
      load_data_o <= mem_q[addr_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      load_v_o <= 1'b0;
    end else begin
      load_v_o <= v_i & ~w_i;
    end
  end

  // the lsu builds a mask for every store it sends here
  a_mask_set: assert property (@(posedge clk_i) disable iff (!reset_i)
    v_i && w_i |-> mask_i != '0)
    else $error("store with empty byte mask");

endmodule

// File: src/remote_req_fifo.sv
// remote request buffer
`timescale 1ns/1ps

module remote_req_fifo
  import lsu_pkg::*;
(
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             push_i,
  input  logic [REQ_W-1:0] req_i,
  input  logic             pop_i,
  output logic             head_v_o,
  output logic [REQ_W-1:0] head_req_o,
  output logic             credit_o
);

  logic [REQ_W-1:0]      mem_q [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_CNT_W-1:0] count_q;

  assign head_v_o   = (count_q != '0);
  assign head_req_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // slot freed, hand a credit back to the producer
      credit_o <= pop_i;
    end
  end

  // producer credits keep a slot free for every push
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!reset_i)
    push_i |-> count_q < FIFO_CNT_W'(FIFO_DEPTH))
    else $error("push into a full request buffer");

  // sender only pops what it has seen at the head
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!reset_i)
    pop_i |-> count_q != '0)
    else $error("pop from an empty request buffer");

endmodule

// File: src/remote_tx.sv
// remote request flit sender
`timescale 1ns/1ps

module remote_tx
  import lsu_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              head_v_i,
  input  logic [REQ_W-1:0]  head_req_i,
  input  logic              net_credit_i,
  output logic              pop_o,
  output logic              net_v_o,
  output logic [FLIT_W-1:0] net_flit_o
);

  logic                 state_q;
  logic [NET_CNT_W-1:0] credits_q;
  logic [OP_W-1:0]      op;
  logic                 has_payload;
  logic                 send;
  logic                 last;
  logic [FLIT_W-1:0]    hdr_flit;
  logic [FLIT_W-1:0]    data_flit;

  assign op          = head_req_i[REQ_OP_LSB +: OP_W];
  assign has_payload = (op == OP_STORE) || (op == OP_AMO);
  assign send        = head_v_i && (credits_q != '0);
  assign last        = (state_q == TX_DATA) || !has_payload;

  // pop as the request's last flit is launched
  assign pop_o = send && last;

  always_comb begin
    hdr_flit = '0;
    hdr_flit[FLIT_KIND_BIT]     = FLIT_HDR;
    hdr_flit[FLIT_WRITE_BIT]    = (op == OP_STORE);
    hdr_flit[FLIT_AMO_BIT]      = (op == OP_AMO);
    hdr_flit[FLIT_ICACHE_BIT]   = head_req_i[REQ_ICACHE_BIT];
    hdr_flit[FLIT_UNSIGNED_BIT] = head_req_i[REQ_UNSIGNED_BIT];
    hdr_flit[FLIT_SIZE_LSB +: SIZE_W]     = head_req_i[REQ_SIZE_LSB +: SIZE_W];
    hdr_flit[FLIT_PSEL_LSB +: 2]          = head_req_i[REQ_PSEL_LSB +: 2];
    hdr_flit[FLIT_MASK_LSB +: MASK_W]     = head_req_i[REQ_MASK_LSB +: MASK_W];
    hdr_flit[FLIT_REG_LSB +: REG_ADDR_W]  = head_req_i[REQ_REG_LSB +: REG_ADDR_W];
    // word address only
    hdr_flit[FLIT_ADDR_LSB +: FLIT_ADDR_W] = head_req_i[REQ_ADDR_LSB + 2 +: FLIT_ADDR_W];

    data_flit = '0;
    data_flit[FLIT_KIND_BIT]              = FLIT_DATA;
    data_flit[FLIT_MASK_LSB +: MASK_W]    = head_req_i[REQ_MASK_LSB +: MASK_W];
    data_flit[FLIT_DATA_LSB +: DATA_W]    = head_req_i[REQ_DATA_LSB +: DATA_W];
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      state_q   <= TX_HDR;
      net_v_o   <= 1'b0;
      credits_q <= NET_CNT_W'(NET_CREDITS);
    end else begin
      net_v_o <= send;
      if (send) begin
        state_q <= last ? TX_HDR : TX_DATA;
      end
      case ({send, net_credit_i})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: credits_q <= credits_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (send) begin
      net_flit_o <= (state_q == TX_HDR) ? hdr_flit : data_flit;
    end
  end

  // network returns at most one credit per flit sent
  a_net_credit_max: assert property (@(posedge clk_i) disable iff (!reset_i)
    credits_q <= NET_CNT_W'(NET_CREDITS))
    else $error("network credits above reset value");

endmodule

// File: src/lsu_tile.sv
// tile memory access top
`timescale 1ns/1ps

module lsu_tile
  import lsu_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  exe_v_i,
  input  logic [OP_W-1:0]       exe_op_i,
  input  logic [SIZE_W-1:0]     exe_size_i,
  input  logic [DATA_W-1:0]     exe_rs1_i,
  input  logic [DATA_W-1:0]     exe_rs2_i,
  input  logic [REG_ADDR_W-1:0] exe_rd_i,
  input  logic [DATA_W-1:0]     mem_offset_i,
  input  logic [DATA_W-1:0]     pc_plus4_i,
  input  logic                  icache_miss_i,
  input  logic [TG_X_W-1:0]     tg_x_cord_i,
  input  logic [TG_Y_W-1:0]     tg_y_cord_i,
  input  logic                  net_credit_i,
  output logic                  stall_o,
  output logic                  load_v_o,
  output logic [DATA_W-1:0]     load_data_o,
  output logic                  reserve_o,
  output logic                  net_v_o,
  output logic [FLIT_W-1:0]     net_flit_o
);

  logic                   dmem_v;
  logic                   dmem_w;
  logic [DMEM_ADDR_W-1:0] dmem_addr;
  logic [DATA_W-1:0]      dmem_data;
  logic [MASK_W-1:0]      dmem_mask;
  logic                   fifo_push;
  logic [REQ_W-1:0]       fifo_req;
  logic                   fifo_credit;
  logic                   head_v;
  logic [REQ_W-1:0]       head_req;
  logic                   pop;

  lsu u_lsu (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .exe_v_i       (exe_v_i),
    .exe_op_i      (exe_op_i),
    .exe_size_i    (exe_size_i),
    .exe_rs1_i     (exe_rs1_i),
    .exe_rs2_i     (exe_rs2_i),
    .exe_rd_i      (exe_rd_i),
    .mem_offset_i  (mem_offset_i),
    .pc_plus4_i    (pc_plus4_i),
    .icache_miss_i (icache_miss_i),
    .tg_x_cord_i   (tg_x_cord_i),
    .tg_y_cord_i   (tg_y_cord_i),
    .fifo_credit_i (fifo_credit),
    .stall_o       (stall_o),
    .dmem_v_o      (dmem_v),
    .dmem_w_o      (dmem_w),
    .dmem_addr_o   (dmem_addr),
    .dmem_data_o   (dmem_data),
    .dmem_mask_o   (dmem_mask),
    .reserve_o     (reserve_o),
    .fifo_push_o   (fifo_push),
    .fifo_req_o    (fifo_req)
  );

  dmem u_dmem (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .v_i         (dmem_v),
    .w_i         (dmem_w),
    .addr_i      (dmem_addr),
    .data_i      (dmem_data),
    .mask_i      (dmem_mask),
    .load_v_o    (load_v_o),
    .load_data_o (load_data_o)
  );

  remote_req_fifo u_fifo (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .push_i     (fifo_push),
    .req_i      (fifo_req),
    .pop_i      (pop),
    .head_v_o   (head_v),
    .head_req_o (head_req),
    .credit_o   (fifo_credit)
  );

  remote_tx u_tx (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .head_v_i     (head_v),
    .head_req_i   (head_req),
    .net_credit_i (net_credit_i),
    .pop_o        (pop),
    .net_v_o      (net_v_o),
    .net_flit_o   (net_flit_o)
  );

endmodule

// File: test/lsu_tb.sv
// lsu tile testbench
`timescale 1ns/1ps

module lsu_tb
  import lsu_pkg::*;
();

  // cycle budget per test, the run may take twice their sum
  localparam int MASKED_CYC  = 600;
  localparam int ROUTE_CYC   = 300;
  localparam int FORMAT_CYC  = 300;
  localparam int MISS_CYC    = 200;
  localparam int RESERVE_CYC = 200;
  localparam int BACKP_CYC   = 400;
  localparam int MAX_CYCLES  = 2 * (MASKED_CYC + ROUTE_CYC + FORMAT_CYC + MISS_CYC +
                                    RESERVE_CYC + BACKP_CYC);
  localparam logic [TG_X_W-1:0] MY_X = 6'd5;
  localparam logic [TG_Y_W-1:0] MY_Y = 5'd3;

  logic                  clk_i;
  logic                  reset_i;
  logic                  exe_v_i;
  logic [OP_W-1:0]       exe_op_i;
  logic [SIZE_W-1:0]     exe_size_i;
  logic [DATA_W-1:0]     exe_rs1_i;
  logic [DATA_W-1:0]     exe_rs2_i;
  logic [REG_ADDR_W-1:0] exe_rd_i;
  logic [DATA_W-1:0]     mem_offset_i;
  logic [DATA_W-1:0]     pc_plus4_i;
  logic                  icache_miss_i;
  logic [TG_X_W-1:0]     tg_x_cord_i;
  logic [TG_Y_W-1:0]     tg_y_cord_i;
  logic                  net_credit_i;
  logic                  stall_o;
  logic                  load_v_o;
  logic [DATA_W-1:0]     load_data_o;
  logic                  reserve_o;
  logic                  net_v_o;
  logic [FLIT_W-1:0]     net_flit_o;

  integer            seed;
  int                errors = 0;
  int                tests_run = 0;
  int                tests_bad = 0;
  int                load_pulses = 0;
  int                cycles = 0;
  int                owed = 0;
  bit                withhold = 1'b0;
  logic [FLIT_W-1:0] front;
  logic [DATA_W-1:0] shadow [DMEM_WORDS];
  logic [FLIT_W-1:0] exp_q [$];

  lsu_tile dut (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .exe_v_i       (exe_v_i),
    .exe_op_i      (exe_op_i),
    .exe_size_i    (exe_size_i),
    .exe_rs1_i     (exe_rs1_i),
    .exe_rs2_i     (exe_rs2_i),
    .exe_rd_i      (exe_rd_i),
    .mem_offset_i  (mem_offset_i),
    .pc_plus4_i    (pc_plus4_i),
    .icache_miss_i (icache_miss_i),
    .tg_x_cord_i   (tg_x_cord_i),
    .tg_y_cord_i   (tg_y_cord_i),
    .net_credit_i  (net_credit_i),
    .stall_o       (stall_o),
    .load_v_o      (load_v_o),
    .load_data_o   (load_data_o),
    .reserve_o     (reserve_o),
    .net_v_o       (net_v_o),
    .net_flit_o    (net_flit_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic value_error(input string msg);
    errors++;
    $display("[ERROR] %0t ns: %s", $time, msg);
  endtask

  task automatic plain_fail(input string msg);
    errors++;
    $display("check failed at %0t ns: %s", $time, msg);
  endtask

  // network side, checks each flit in order and hands back its credit
  always @(negedge clk_i) begin
    if (load_v_o) begin
      load_pulses++;
    end
    if (net_v_o) begin
      assert (exp_q.size() != 0)
        else plain_fail($sformatf("flit %h arrived when none was expected", net_flit_o));
      if (exp_q.size() != 0) begin
        front = exp_q.pop_front();
        assert (net_flit_o === front)
          else value_error($sformatf("flit got %h exp %h", net_flit_o, front));
      end
    end
    if (!reset_i) begin
      owed = 0;
      net_credit_i = 1'b0;
    end else begin
      if (net_v_o) begin
        owed++;
      end
      if (!withhold && owed > 0) begin
        net_credit_i = 1'b1;
        owed--;
      end else begin
        net_credit_i = 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("timeout after %0d cycles, run stopped", MAX_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  function automatic logic [DATA_W-1:0] tg_addr(input logic [TG_X_W-1:0] x,
                                                 input logic [TG_Y_W-1:0] y,
                                                 input logic [TG_EPA_W-1:0] epa);
    lsu_addr_u a;
    a.tg.remote = TG_REMOTE_TAG;
    a.tg.y_cord = y;
    a.tg.x_cord = x;
    a.tg.epa    = epa;
    return a;
  endfunction

  function automatic logic [DATA_W-1:0] plain_addr(input logic [19:0] upper,
                                                    input logic [11:0] offset);
    lsu_addr_u a;
    a.plain.upper  = upper;
    a.plain.offset = offset;
    return a;
  endfunction

  function automatic logic [MASK_W-1:0] mask_for(input logic [SIZE_W-1:0] size,
                                                  input logic [1:0] low);
    case (size)
      SIZE_BYTE: return 4'b0001 << low;
      SIZE_HALF: return low[1] ? 4'b1100 : 4'b0011;
      default:   return 4'b1111;
    endcase
  endfunction

  function automatic logic [DATA_W-1:0] replicate(input logic [SIZE_W-1:0] size,
                                                   input logic [DATA_W-1:0] data);
    case (size)
      SIZE_BYTE: return {4{data[7:0]}};
      SIZE_HALF: return {2{data[15:0]}};
      default:   return data;
    endcase
  endfunction

  function automatic logic [FLIT_W-1:0] make_header(input logic write, input logic amo,
      input logic icache, input logic uns, input logic [SIZE_W-1:0] size,
      input logic [1:0] psel, input logic [MASK_W-1:0] mask,
      input logic [REG_ADDR_W-1:0] rd, input logic [DATA_W-1:0] addr);
    logic [FLIT_W-1:0] f;
    f = '0;
    f[FLIT_KIND_BIT]                   = FLIT_HDR;
    f[FLIT_WRITE_BIT]                  = write;
    f[FLIT_AMO_BIT]                    = amo;
    f[FLIT_ICACHE_BIT]                 = icache;
    f[FLIT_UNSIGNED_BIT]               = uns;
    f[FLIT_SIZE_LSB +: SIZE_W]         = size;
    f[FLIT_PSEL_LSB +: 2]              = psel;
    f[FLIT_MASK_LSB +: MASK_W]         = mask;
    f[FLIT_REG_LSB +: REG_ADDR_W]      = rd;
    f[FLIT_ADDR_LSB +: FLIT_ADDR_W]    = addr[DATA_W-1:2];
    return f;
  endfunction

  task automatic expect_remote(input logic [OP_W-1:0] op, input logic [SIZE_W-1:0] size,
      input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] data,
      input logic [REG_ADDR_W-1:0] rd);
    logic [MASK_W-1:0] m;
    logic [FLIT_W-1:0] f;
    m = mask_for(size, addr[1:0]);
    exp_q.push_back(make_header(op == OP_STORE, op == OP_AMO, 1'b0, op == OP_LOAD_U,
                                size, addr[1:0], m, rd, addr));
    // stores and atomics carry their data in a second flit
    if (op == OP_STORE || op == OP_AMO) begin
      f = '0;
      f[FLIT_KIND_BIT]              = FLIT_DATA;
      f[FLIT_MASK_LSB +: MASK_W]    = m;
      f[FLIT_DATA_LSB +: DATA_W]    = replicate(size, data);
      exp_q.push_back(f);
    end
  endtask

  // addr doubles as pc_plus4 on a miss
  task automatic present(input logic [OP_W-1:0] op, input logic [SIZE_W-1:0] size,
      input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] data,
      input logic [REG_ADDR_W-1:0] rd, input logic miss);
    logic [DATA_W-1:0] off;
    off = $random(seed) & 32'hff;
    @(negedge clk_i);
    exe_v_i       = 1'b1;
    exe_op_i      = op;
    exe_size_i    = size;
    exe_rs1_i     = addr - off;
    mem_offset_i  = off;
    exe_rs2_i     = data;
    exe_rd_i      = rd;
    icache_miss_i = miss;
    if (miss) begin
      pc_plus4_i = addr;
    end
  endtask

  task automatic accept_wait();
    #1;
    while (stall_o) begin
      @(negedge clk_i);
      #1;
    end
    @(posedge clk_i);
    @(negedge clk_i);
    exe_v_i       = 1'b0;
    icache_miss_i = 1'b0;
  endtask

  task automatic issue(input logic [OP_W-1:0] op, input logic [SIZE_W-1:0] size,
      input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] data,
      input logic [REG_ADDR_W-1:0] rd, input logic miss);
    present(op, size, addr, data, rd, miss);
    accept_wait();
  endtask

  task automatic remote_op(input logic [OP_W-1:0] op, input logic [SIZE_W-1:0] size,
      input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] data,
      input logic [REG_ADDR_W-1:0] rd);
    expect_remote(op, size, addr, data, rd);
    issue(op, size, addr, data, rd, 1'b0);
  endtask

  task automatic drain();
    do begin
      @(negedge clk_i);
      #1;
    end while (exp_q.size() != 0);
    // room for a duplicate flit to show up
    repeat (6) @(negedge clk_i);
  endtask

  // read data must land exactly two cycles after acceptance
  task automatic check_load(input int w, input logic [DATA_W-1:0] addr);
    issue(OP_LOAD, SIZE_WORD, addr, '0, 5'd1, 1'b0);
    assert (load_v_o === 1'b0)
      else value_error("load_v_o one cycle early");
    @(negedge clk_i);
    assert (load_v_o === 1'b1 && load_data_o === shadow[w])
      else value_error($sformatf("load word %0d v %b got %h exp %h",
                                 w, load_v_o, load_data_o, shadow[w]));
  endtask

  task automatic store_word(input int w);
    logic [DATA_W-1:0] d;
    d = $random(seed);
    issue(OP_STORE, SIZE_WORD, w * 4, d, '0, 1'b0);
    shadow[w] = d;
  endtask

  task automatic finish_test(input string name, input int start);
    tests_run++;
    if (errors == start) begin
      $display("%s: ok", name);
    end else begin
      tests_bad++;
      $display("%s: %0d errors", name, errors - start);
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    reset_i = 1'b0;
    repeat (8) @(negedge clk_i);
    reset_i = 1'b1;
  endtask

  task automatic masked_local_access();
    int start;
    int w;
    logic [DATA_W-1:0] d;
    start = errors;
    for (int n = 0; n < 4; n++) begin
      w = {$random(seed)} % DMEM_WORDS;
      store_word(w);
      check_load(w, w * 4);
      for (int b = 0; b < 4; b++) begin
        d = $random(seed);
        issue(OP_STORE, SIZE_BYTE, w * 4 + b, d, '0, 1'b0);
        shadow[w][8*b +: 8] = d[7:0];
      end
      check_load(w, w * 4);
      for (int p = 0; p < 4; p += 2) begin
        d = $random(seed);
        issue(OP_STORE, SIZE_HALF, w * 4 + p, d, '0, 1'b0);
        shadow[w][8*p +: 16] = d[15:0];
      end
      check_load(w, w * 4);
    end
    finish_test("masked local access", start);
  endtask

  task automatic address_routing();
    int start;
    int w;
    int pulses;
    start = errors;
    w = {$random(seed)} % DMEM_WORDS;
    store_word(w);
    // own coordinates decode local
    check_load(w, tg_addr(MY_X, MY_Y, w * 4));
    // let the local pulse be counted first
    #1;
    pulses = load_pulses;
    remote_op(OP_LOAD, SIZE_WORD, tg_addr(MY_X + 6'd1, MY_Y, w * 4), '0, 5'd7);
    remote_op(OP_LOAD, SIZE_WORD, tg_addr(MY_X, MY_Y + 5'd1, w * 4), '0, 5'd8);
    remote_op(OP_LOAD, SIZE_WORD, plain_addr(20'h00040, 12'(w * 4)), '0, 5'd9);
    drain();
    assert (load_pulses == pulses)
      else plain_fail("a remote address also produced a local load");
    finish_test("address routing", start);
  endtask

  task automatic remote_flit_format();
    int start;
    int w;
    logic [DATA_W-1:0] base;
    start = errors;
    base = tg_addr(MY_X + 6'd2, MY_Y, TG_EPA_W'({$random(seed)}) & 18'h3fffc);
    remote_op(OP_LOAD_U, SIZE_BYTE, base + 3, '0, REG_ADDR_W'($random(seed)));
    remote_op(OP_LOAD, SIZE_HALF, base + 2, '0, REG_ADDR_W'($random(seed)));
    remote_op(OP_STORE, SIZE_HALF, base + 2, $random(seed), '0);
    remote_op(OP_STORE, SIZE_BYTE, base + 1, $random(seed), '0);
    // an atomic at a local address still leaves the tile
    w = {$random(seed)} % DMEM_WORDS;
    store_word(w);
    remote_op(OP_AMO, SIZE_WORD, w * 4, $random(seed), REG_ADDR_W'($random(seed)));
    drain();
    check_load(w, w * 4);
    finish_test("remote flit format", start);
  endtask

  task automatic icache_miss_fetch();
    int start;
    logic [DATA_W-1:0] pc;
    start = errors;
    for (int n = 0; n < 2; n++) begin
      pc = $random(seed);
      exp_q.push_back(make_header(1'b0, 1'b0, 1'b1, 1'b0, SIZE_WORD, 2'b00, 4'b1111, '0,
                                  (pc - 32'd4) | DRAM_PREFIX));
      issue((n == 0) ? OP_STORE : OP_NONE, SIZE_BYTE, pc, $random(seed), 5'd4, 1'b1);
    end
    drain();
    finish_test("instruction miss fetch", start);
  endtask

  task automatic reservation();
    int start;
    int w;
    start = errors;
    w = {$random(seed)} % DMEM_WORDS;
    store_word(w);
    issue(OP_LR, SIZE_WORD, w * 4, '0, 5'd3, 1'b0);
    assert (reserve_o === 1'b1)
      else value_error("reserve_o low after local load-reserved");
    @(negedge clk_i);
    assert (reserve_o === 1'b0)
      else value_error("reserve_o held longer than one cycle");
    issue(OP_LOAD, SIZE_WORD, w * 4, '0, 5'd3, 1'b0);
    assert (reserve_o === 1'b0)
      else value_error("reserve_o high after plain load");
    issue(OP_LR, SIZE_WORD, tg_addr(MY_X, MY_Y, w * 4), '0, 5'd3, 1'b0);
    assert (reserve_o === 1'b1)
      else value_error("reserve_o low after tile-group load-reserved");
    issue(OP_LR_AQ, SIZE_WORD, w * 4, '0, 5'd3, 1'b0);
    assert (reserve_o === 1'b1)
      else value_error("reserve_o low after load-reserved acquire");
    finish_test("reservation", start);
  endtask

  task automatic backpressure_and_reset();
    int start;
    bit stalled;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] d;
    start = errors;
    stalled = 1'b0;
    drain();
    // a local load-reserved stays valid while reset is applied
    present(OP_LR, SIZE_WORD, 32'h0000_0010, '0, 5'd2, 1'b0);
    apply_reset();
    exe_v_i = 1'b0;
    assert (!stall_o && !net_v_o && !load_v_o && !reserve_o)
      else value_error($sformatf("outputs after reset stall %b net %b load %b resv %b",
                                 stall_o, net_v_o, load_v_o, reserve_o));
    withhold = 1'b1;
    for (int i = 0; i < 8 && !stalled; i++) begin
      a = tg_addr(MY_X + 6'd3, MY_Y, TG_EPA_W'(i * 4));
      d = $random(seed);
      present(OP_STORE, SIZE_WORD, a, d, '0, 1'b0);
      #1;
      if (stall_o) begin
        stalled = 1'b1;
      end else begin
        expect_remote(OP_STORE, SIZE_WORD, a, d, '0);
        @(posedge clk_i);
      end
    end
    @(negedge clk_i);
    exe_v_i = 1'b0;
    assert (stalled)
      else plain_fail("stall never rose while network credits were withheld");
    withhold = 1'b0;
    drain();
    finish_test("back-pressure and reset", start);
  endtask

  initial begin
    seed          = 32'h9a16ed6d;
    reset_i       = 1'b0;
    exe_v_i       = 1'b0;
    exe_op_i      = OP_NONE;
    exe_size_i    = SIZE_WORD;
    exe_rs1_i     = '0;
    exe_rs2_i     = '0;
    exe_rd_i      = '0;
    mem_offset_i  = '0;
    pc_plus4_i    = '0;
    icache_miss_i = 1'b0;
    tg_x_cord_i   = MY_X;
    tg_y_cord_i   = MY_Y;
    net_credit_i  = 1'b0;
    apply_reset();
    masked_local_access();
    address_routing();
    remote_flit_format();
    icache_miss_fetch();
    reservation();
    backpressure_and_reset();
    $display("tests: %0d run, %0d failing, %0d errors", tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: compile.f
src/lsu_pkg.sv
src/lsu.sv
src/dmem.sv
src/remote_req_fifo.sv
src/remote_tx.sv
src/lsu_tile.sv
test/lsu_tb.sv

// File: Bender.yml
package:
  name: lsu_tile

sources:
  - src/lsu_pkg.sv
  - src/lsu.sv
  - src/dmem.sv
  - src/remote_req_fifo.sv
  - src/remote_tx.sv
  - src/lsu_tile.sv
  - target: test
    files:
      - test/lsu_tb.sv
